//--- imuldiv_pkg.sv
// ----------------------------------------------------------------------
// shared types and constants for the iterative mul/div unit
// ----------------------------------------------------------------------

package imuldiv_pkg;

  // ----------------------------------------------------------------------
  // widths
  // ----------------------------------------------------------------------

  // one request operand at the default width
  typedef logic [31:0] operand_t;

  // one response word
  // mul gives the full product
  // div gives {remainder, quotient}
  typedef logic [63:0] result_t;

  // ----------------------------------------------------------------------
  // function codes
  // ----------------------------------------------------------------------

  // 2'd3 is not a legal code
  // decode sends it to the divider as unsigned
  typedef enum logic [1:0] {
    fn_mul  = 2'd0,
    fn_div  = 2'd1,
    fn_divu = 2'd2
  } muldiv_fn_t;

  // ----------------------------------------------------------------------
  // iteration count
  // ----------------------------------------------------------------------

  // one shift-add or shift-subtract step per operand bit
  localparam int num_iters = 32;

endpackage

//--- imuldiv_decode.sv
// ----------------------------------------------------------------------
// request side: accept, busy tracking, operand capture, start routing
// ----------------------------------------------------------------------

`timescale 1ns/1ns

module imuldiv_decode #(
  parameter int xlen = 32
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    req_val,
  input  imuldiv_pkg::muldiv_fn_t req_fn,
  input  logic [xlen-1:0]         req_a,
  input  logic [xlen-1:0]         req_b,
  output logic                    req_rdy,
  input  logic                    resp_fire,
  output logic                    mul_start,
  output logic                    div_start,
  output logic                    div_signed,
  output logic [xlen-1:0]         op_a,
  output logic [xlen-1:0]         op_b
);

  // high from accept until the response has gone out
  logic busy;
  logic accept;

  assign req_rdy = ~busy;
  assign accept  = req_val & ~busy;

  // busy flag and one-cycle start strobes
  always_ff @(posedge clk) begin
    if (reset) begin
      busy      <= 1'b0;
      mul_start <= 1'b0;
      div_start <= 1'b0;
    end else begin
      mul_start <= accept & (req_fn == imuldiv_pkg::fn_mul);
      div_start <= accept & (req_fn != imuldiv_pkg::fn_mul);
      if (accept) begin
        busy <= 1'b1;
      end else if (resp_fire) begin
        busy <= 1'b0;
      end
    end
  end

  // operands and signedness, valid alongside the start strobe
  always_ff @(posedge clk) begin
    if (accept) begin
      op_a       <= req_a;
      op_b       <= req_b;
      div_signed <= (req_fn == imuldiv_pkg::fn_div);
    end
  end

endmodule

//--- imuldiv_mul_iterative.sv
// ----------------------------------------------------------------------
// iterative signed shift-add multiplier, FSM and datapath
// ----------------------------------------------------------------------

`timescale 1ns/1ns

module imuldiv_mul_iterative #(
  parameter int xlen = 32
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 start,
  input  logic [xlen-1:0]      op_a,
  input  logic [xlen-1:0]      op_b,
  output logic                 done,
  output logic [2*xlen-1:0]    value
);

  localparam int cnt_w = $clog2(xlen);

  typedef enum logic [1:0] {
    s_idle,
    s_calc,
    s_done
  } state_t;

  state_t           state;
  logic [cnt_w-1:0] count;

  // operand signs, kept for the final negate
  logic sign_a;
  logic sign_b;

  // magnitudes of the incoming operands
  logic [xlen-1:0] mag_a;
  logic [xlen-1:0] mag_b;

  // multiplicand shifts left, multiplier shifts right
  logic [2*xlen-1:0] mcand;
  logic [xlen-1:0]   mplier;
  logic [2*xlen-1:0] acc;

  assign mag_a = op_a[xlen-1] ? (~op_a + 1'b1) : op_a;
  assign mag_b = op_b[xlen-1] ? (~op_b + 1'b1) : op_b;

  // ----------------------------------------------------------------------
  // control
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= s_idle;
      count <= '0;
    end else begin
      case (state)
        s_idle: begin
          if (start) begin
            state <= s_calc;
            count <= '0;
          end
        end
        s_calc: begin
          // last step when the counter reaches xlen-1
          if (count == cnt_w'(xlen - 1)) begin
            state <= s_done;
          end else begin
            count <= count + 1'b1;
          end
        end
        s_done: begin
          state <= s_idle;
        end
        default: begin
          state <= s_idle;
        end
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // datapath
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (state == s_idle && start) begin
      sign_a <= op_a[xlen-1];
      sign_b <= op_b[xlen-1];
      mcand  <= {{xlen{1'b0}}, mag_a};
      mplier <= mag_b;
      acc    <= '0;
    end else if (state == s_calc) begin
      // add only when the current multiplier bit is set
      if (mplier[0]) begin
        acc <= acc + mcand;
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  // product is negative when exactly one operand was
  assign value = (sign_a ^ sign_b) ? (~acc + 1'b1) : acc;
  assign done  = (state == s_done);

endmodule

//--- imuldiv_div_iterative.sv
// ----------------------------------------------------------------------
// iterative restoring divider, signed and unsigned
// ----------------------------------------------------------------------

`timescale 1ns/1ns

module imuldiv_div_iterative #(
  parameter int xlen = 32
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 start,
  input  logic                 signed_op,
  input  logic [xlen-1:0]      op_a,
  input  logic [xlen-1:0]      op_b,
  output logic                 done,
  output logic [2*xlen-1:0]    value
);

  localparam int cnt_w = $clog2(xlen);

  typedef enum logic [1:0] {
    s_idle,
    s_calc,
    s_done
  } state_t;

  state_t           state;
  logic [cnt_w-1:0] count;

  // signs only count for the signed function
  logic neg_a;
  logic neg_b;
  logic sign_a;
  logic sign_b;

  logic [xlen-1:0] mag_a;
  logic [xlen-1:0] mag_b;

  // quotient register starts as the dividend and fills from the right
  logic [xlen-1:0] quot;
  logic [xlen-1:0] rem;
  logic [xlen-1:0] divisor;

  // one extra bit so the borrow shows up on top
  logic [xlen:0] rem_shift;
  logic [xlen:0] diff;

  logic [xlen-1:0] quot_out;
  logic [xlen-1:0] rem_out;

  assign neg_a = signed_op & op_a[xlen-1];
  assign neg_b = signed_op & op_b[xlen-1];
  assign mag_a = neg_a ? (~op_a + 1'b1) : op_a;
  assign mag_b = neg_b ? (~op_b + 1'b1) : op_b;

  assign rem_shift = {rem, quot[xlen-1]};
  assign diff      = rem_shift - {1'b0, divisor};

  // ----------------------------------------------------------------------
  // control
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= s_idle;
      count <= '0;
    end else begin
      case (state)
        s_idle: begin
          if (start) begin
            state <= s_calc;
            count <= '0;
          end
        end
        s_calc: begin
          if (count == cnt_w'(xlen - 1)) begin
            state <= s_done;
          end else begin
            count <= count + 1'b1;
          end
        end
        s_done: begin
          state <= s_idle;
        end
        default: begin
          state <= s_idle;
        end
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // datapath
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (state == s_idle && start) begin
      sign_a  <= neg_a;
      sign_b  <= neg_b;
      quot    <= mag_a;
      rem     <= '0;
      divisor <= mag_b;
    end else if (state == s_calc) begin
      // keep the difference only if it did not borrow
      if (!diff[xlen]) begin
        rem  <= diff[xlen-1:0];
        quot <= {quot[xlen-2:0], 1'b1};
      end else begin
        rem  <= rem_shift[xlen-1:0];
        quot <= {quot[xlen-2:0], 1'b0};
      end
    end
  end

  // quotient truncates toward zero, remainder follows the dividend
  assign quot_out = (sign_a ^ sign_b) ? (~quot + 1'b1) : quot;
  assign rem_out  = sign_a ? (~rem + 1'b1) : rem;

  assign value = {rem_out, quot_out};
  assign done  = (state == s_done);

endmodule

//--- imuldiv_result.sv
// ----------------------------------------------------------------------
// response side: result capture and valid/ready handshake
// ----------------------------------------------------------------------

`timescale 1ns/1ns

module imuldiv_result (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 mul_done,
  input  imuldiv_pkg::result_t mul_value,
  input  logic                 div_done,
  input  imuldiv_pkg::result_t div_value,
  input  logic                 resp_rdy,
  output logic                 resp_val,
  output imuldiv_pkg::result_t resp_result,
  output logic                 resp_fire
);

  assign resp_fire = resp_val & resp_rdy;

  // valid rises the cycle after a done strobe, drops after the handshake
  always_ff @(posedge clk) begin
    if (reset) begin
      resp_val <= 1'b0;
    end else if (mul_done || div_done) begin
      resp_val <= 1'b1;
    end else if (resp_fire) begin
      resp_val <= 1'b0;
    end
  end

  // holding register
  // only one unit is busy at a time, so the strobes never overlap
  always_ff @(posedge clk) begin
    if (mul_done) begin
      resp_result <= mul_value;
    end else if (div_done) begin
      resp_result <= div_value;
    end
  end

endmodule

//--- imuldiv_top.sv
// ----------------------------------------------------------------------
// top level: decode, multiplier, divider and result
// ----------------------------------------------------------------------

`timescale 1ns/1ns

module imuldiv_top #(
  // one iteration per operand bit
  parameter int xlen = imuldiv_pkg::num_iters
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    req_val,
  input  imuldiv_pkg::muldiv_fn_t req_fn,
  input  imuldiv_pkg::operand_t   req_a,
  input  imuldiv_pkg::operand_t   req_b,
  output logic                    req_rdy,
  output logic                    resp_val,
  output imuldiv_pkg::result_t    resp_result,
  input  logic                    resp_rdy
);

  // decode to execute
  logic            mul_start;
  logic            div_start;
  logic            div_signed;
  logic [xlen-1:0] op_a;
  logic [xlen-1:0] op_b;

  // execute to result
  logic              mul_done;
  logic              div_done;
  logic [2*xlen-1:0] mul_value;
  logic [2*xlen-1:0] div_value;

  // result back to decode
  logic resp_fire;

  imuldiv_decode #(.xlen(xlen)) u_decode (
    .clk(clk), .reset(reset),
    .req_val(req_val), .req_fn(req_fn), .req_a(req_a), .req_b(req_b),
    .req_rdy(req_rdy), .resp_fire(resp_fire),
    .mul_start(mul_start), .div_start(div_start), .div_signed(div_signed),
    .op_a(op_a), .op_b(op_b)
  );

  imuldiv_mul_iterative #(.xlen(xlen)) u_mul (
    .clk(clk), .reset(reset), .start(mul_start),
    .op_a(op_a), .op_b(op_b), .done(mul_done), .value(mul_value)
  );

  imuldiv_div_iterative #(.xlen(xlen)) u_div (
    .clk(clk), .reset(reset), .start(div_start), .signed_op(div_signed),
    .op_a(op_a), .op_b(op_b), .done(div_done), .value(div_value)
  );

  imuldiv_result u_result (
    .clk(clk), .reset(reset),
    .mul_done(mul_done), .mul_value(mul_value),
    .div_done(div_done), .div_value(div_value),
    .resp_rdy(resp_rdy), .resp_val(resp_val),
    .resp_result(resp_result), .resp_fire(resp_fire)
  );

endmodule

//--- imuldiv_props.sv
// ----------------------------------------------------------------------
// bound handshake and one-in-flight checks for the mul/div unit
// ----------------------------------------------------------------------

`timescale 1ns/1ns

module imuldiv_props (
  input logic                 clk,
  input logic                 reset,
  input logic                 req_rdy,
  input logic                 resp_val,
  input logic                 resp_rdy,
  input imuldiv_pkg::result_t resp_result
);

  // no new request while a response waits
  assert property (@(posedge clk) disable iff (reset) resp_val |-> !req_rdy)
    else $error("req_rdy high while a response is pending");

  // response held under back-pressure
  assert property (@(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> resp_val && $stable(resp_result))
    else $error("response dropped or changed while resp_rdy was low");

  assert property (@(posedge clk) disable iff (reset) resp_val && resp_rdy |=> !resp_val)
    else $error("resp_val still high after the handshake");

endmodule

bind imuldiv_top imuldiv_props u_props (
  .clk(clk), .reset(reset), .req_rdy(req_rdy), .resp_val(resp_val),
  .resp_rdy(resp_rdy), .resp_result(resp_result)
);

//--- imuldiv_tb.sv
// ----------------------------------------------------------------------
// testbench for the mul/div unit, driven from the golden vector file
// ----------------------------------------------------------------------

`timescale 1ns/1ns

module imuldiv_tb;

  logic                    clk;
  logic                    reset;
  logic                    req_val;
  imuldiv_pkg::muldiv_fn_t req_fn;
  imuldiv_pkg::operand_t   req_a;
  imuldiv_pkg::operand_t   req_b;
  logic                    req_rdy;
  logic                    resp_val;
  imuldiv_pkg::result_t    resp_result;
  logic                    resp_rdy;

  // vectors as read from the golden file
  string                 names[$];
  logic [1:0]            fn_q[$];
  imuldiv_pkg::operand_t a_q[$];
  imuldiv_pkg::operand_t b_q[$];
  imuldiv_pkg::result_t  exp_q[$];

  int          errors = 0;
  int          checks = 0;
  logic        loaded = 1'b0;
  logic [31:0] seed   = 32'hd9b;

  imuldiv_top UUT (.*);

  always #4 clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check_flag(input string what, input logic expected, input logic actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("ERROR %s: expected %0b, actual %0b", what, expected, actual);
    end
  endtask

  // ----------------------------------------------------------------------
  // golden file reader
  // ----------------------------------------------------------------------

  task automatic load_vectors();
    int                    fd;
    int                    fn_code;
    string                 line;
    string                 name;
    imuldiv_pkg::operand_t a;
    imuldiv_pkg::operand_t b;
    imuldiv_pkg::result_t  expected;
    fd = $fopen("imuldiv_golden.txt", "r");
    if (fd == 0) begin
      return;
    end
    while ($fgets(line, fd) > 0) begin
      // lines starting with # hold the column legend
      if (line.substr(0, 0) != "#" &&
          $sscanf(line, "%s %d %h %h %h", name, fn_code, a, b, expected) == 5) begin
        names.push_back(name);
        fn_q.push_back(fn_code[1:0]);
        a_q.push_back(a);
        b_q.push_back(b);
        exp_q.push_back(expected);
      end
    end
    $fclose(fd);
  endtask

  // ----------------------------------------------------------------------
  // one request and its response, with random back-pressure
  // ----------------------------------------------------------------------

  task automatic run_vector(input int i);
    int delay;
    @(posedge clk);
    #1;
    req_val = 1'b1;
    req_fn  = imuldiv_pkg::muldiv_fn_t'(fn_q[i]);
    req_a   = a_q[i];
    req_b   = b_q[i];
    // hold the request until the DUT can take it
    while (!req_rdy) begin
      @(posedge clk);
      #1;
    end
    @(posedge clk);
    #1;
    req_val = 1'b0;
    check_flag({names[i], " req_rdy after accept"}, 1'b0, req_rdy);
    // one operation in flight, no new request while it runs
    while (!resp_val) begin
      @(posedge clk);
      #1;
      check_flag({names[i], " req_rdy while busy"}, 1'b0, req_rdy);
    end
    // hold off 0 to 3 cycles, the result must stay put
    seed  = lcg_next(seed);
    delay = int'(seed[17:16]);
    repeat (delay) begin
      check_flag({names[i], " req_rdy under back-pressure"}, 1'b0, req_rdy);
      @(posedge clk);
      #1;
    end
    checks++;
    assert (resp_result === exp_q[i]) else begin
      errors++;
      $display("ERROR %s: expected %h, actual %h", names[i], exp_q[i], resp_result);
    end
    resp_rdy = 1'b1;
    @(posedge clk);
    #1;
    resp_rdy = 1'b0;
    check_flag({names[i], " resp_val after handshake"}, 1'b0, resp_val);
    check_flag({names[i], " req_rdy after handshake"}, 1'b1, req_rdy);
  endtask

  initial begin
    clk      = 1'b0;
    reset    = 1'b1;
    req_val  = 1'b0;
    req_fn   = imuldiv_pkg::fn_mul;
    req_a    = '0;
    req_b    = '0;
    resp_rdy = 1'b0;
    load_vectors();
    loaded = 1'b1;
    if (names.size() == 0) begin
      errors++;
      $display("no test vectors could be read from imuldiv_golden.txt");
    end
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;
    check_flag("reset resp_val", 1'b0, resp_val);
    check_flag("reset req_rdy", 1'b1, req_rdy);
    for (int i = 0; i < names.size(); i++) begin
      run_vector(i);
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // hang guard, 60 cycles per vector plus reset margin
  initial begin
    wait (loaded);
    repeat ((names.size() + 2) * 60) @(posedge clk);
    $display("timeout: the DUT stopped responding after %0d checks", checks);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

//--- imuldiv_golden.txt
# name  fn (0 mul, 1 div, 2 divu)  a  b  expected (mul: product, div: remainder then quotient)
mul_mixed 0 00000007 fffffffd ffffffffffffffeb
mul_negneg 0 fffffffb fffffff7 000000000000002d
mul_zero 0 00000000 12345678 0000000000000000
mul_minmin 0 80000000 80000000 4000000000000000
mul_max_min 0 7fffffff 80000000 c000000080000000
div_pos 1 00000064 00000007 000000020000000e
div_neg_dividend 1 ffffff9c 00000007 fffffffefffffff2
div_neg_divisor 1 00000064 fffffff9 00000002fffffff2
div_min_neg1 1 80000000 ffffffff 0000000080000000
divu_topbit 2 80000000 00000003 000000022aaaaaaa
div_by_zero 1 ffffff9c 00000000 ffffff9c00000001
divu_by_zero 2 ffffff9c 00000000 ffffff9cffffffff

//--- vlog.f
imuldiv_pkg.sv
imuldiv_decode.sv
imuldiv_mul_iterative.sv
imuldiv_div_iterative.sv
imuldiv_result.sv
imuldiv_top.sv
imuldiv_props.sv
imuldiv_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module imuldiv_tb -f vlog.f -o imuldiv_sim
output="$(./obj_dir/imuldiv_sim)" || true
echo "$output"
if grep -qxF "Simulation finished: PASS" <<< "$output"; then
  exit 0
fi
exit 1
